// File: armIsaPkg.sv
package armIsaPkg;

   typedef logic [3:0] regIdx;

   // Condition field, ARM encoding
   typedef enum logic [3:0] {
      condEq = 4'b0000, // Z set
      condNe = 4'b0001,
      condCs = 4'b0010, // C set
      condCc = 4'b0011,
      condMi = 4'b0100, // N set
      condPl = 4'b0101,
      condVs = 4'b0110, // V set
      condVc = 4'b0111,
      condHi = 4'b1000, // Unsigned higher
      condLs = 4'b1001,
      condGe = 4'b1010, // Signed compares
      condLt = 4'b1011,
      condGt = 4'b1100,
      condLe = 4'b1101,
      condAl = 4'b1110
   } condCode;

   // Data-processing opcodes in bits 24:21
   typedef enum logic [3:0] {
      opAnd = 4'b0000,
      opEor = 4'b0001,
      opSub = 4'b0010,
      opAdd = 4'b0100,
      opTst = 4'b1000,
      opTeq = 4'b1001,
      opCmp = 4'b1010,
      opCmn = 4'b1011,
      opOrr = 4'b1100,
      opMov = 4'b1101,
      opBic = 4'b1110,
      opMvn = 4'b1111
   } dpOpcode;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flagsT;

   // Immediate form, bit 25 set
   typedef struct packed {
      condCode    cond;
      logic [1:0] op;
      logic       immBit;
      dpOpcode    opcode;
      logic       s;
      regIdx      rn;
      regIdx      rd;
      logic [3:0] zero;   // Rotate field, not supported
      logic [7:0] imm8;
   } dpImmFields;

   // Register form, bit 25 clear
   typedef struct packed {
      condCode    cond;
      logic [1:0] op;
      logic       immBit;
      dpOpcode    opcode;
      logic       s;
      regIdx      rn;
      regIdx      rd;
      logic [7:0] zero;   // Shift field, not supported
      regIdx      rm;
   } dpRegFields;

   typedef union packed {
      dpImmFields immView;
      dpRegFields regView;
   } dpInstr;

endpackage

// File: armCorePkg.sv
package armCorePkg;

   // Datapath word
   typedef logic [31:0] word;

   // Operation selected in decode and carried to the ALU.
   // Compare forms reuse the add, sub, and and eor codes
   // with the register write suppressed.
   typedef enum logic [2:0] {
      aluAdd = 3'd0, // ADD, CMN
      aluSub = 3'd1, // SUB, CMP
      aluAnd = 3'd2, // AND, TST
      aluOrr = 3'd3,
      aluEor = 3'd4, // EOR, TEQ
      aluBic = 3'd5, // a & ~b
      aluMov = 3'd6, // Passes b
      aluMvn = 3'd7  // ~b
   } aluOp;

endpackage

// File: opBus.sv
interface opBus;
   import armIsaPkg::*;
   import armCorePkg::*;

   logic    valid;     // Real, implemented instruction
   aluOp    op;
   condCode cond;
   logic    setFlags;
   logic    arith;     // Add or subtract, updates C and V
   logic    writesReg; // Clear for compare forms
   regIdx   rd;
   regIdx   rn;
   regIdx   rm;
   logic    useImm;
   word     operandA;
   word     operandB;

   modport src (
      output valid, op, cond, setFlags, arith, writesReg,
      output rd, rn, rm, useImm, operandA, operandB
   );

   modport dst (
      input valid, op, cond, setFlags, arith, writesReg,
      input rd, rn, rm, useImm, operandA, operandB
   );

endinterface

// File: regFile.sv
module regFile (
   input  logic               clk,
   input  logic               reset,
   input  armIsaPkg::regIdx   ra1,
   input  armIsaPkg::regIdx   ra2,
   output armCorePkg::word    rd1,
   output armCorePkg::word    rd2,
   input  logic               we,
   input  armIsaPkg::regIdx   wa,
   input  armCorePkg::word    wd,
   input  logic               hold
);
   import armCorePkg::*;

   word regs [16];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
      end else if (we && !hold) begin
         regs[wa] <= wd;
      end
   end

   // Write-first, so decode sees the result being retired
   assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
   assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: aluUnit.sv
module aluUnit (
   input  armCorePkg::word   a,
   input  armCorePkg::word   b,
   input  armCorePkg::aluOp  op,
   output armCorePkg::word   result,
   output armIsaPkg::flagsT  aluFlags
);
   import armCorePkg::*;

   logic        isSub;
   logic        isArith;
   word         bSel;
   logic [32:0] sum;

   assign isSub   = (op == aluSub);
   assign isArith = (op == aluAdd) || isSub;

   // Subtract as a + ~b + 1, carry out is then NOT borrow
   assign bSel = isSub ? ~b : b;
   assign sum  = {1'b0, a} + {1'b0, bSel} + {32'b0, isSub};

   always_comb begin
      case (op)
         aluAdd,
         aluSub:  result = sum[31:0];
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         aluEor:  result = a ^ b;
         aluBic:  result = a & ~b;
         aluMov:  result = b;
         default: result = ~b; // MVN
      endcase
   end

   assign aluFlags.n = result[31];
   assign aluFlags.z = (result == '0);
   assign aluFlags.c = isArith && sum[32];
   // Same-sign operands giving a result of the other sign
   assign aluFlags.v = isArith && (a[31] == bSel[31]) && (sum[31] != a[31]);

endmodule

// File: decodeStage.sv
module decodeStage (
   input  logic               clk,
   input  logic               reset,
   input  logic               hold,
   input  logic               instrValid,
   input  armIsaPkg::dpInstr  instr,
   input  logic               resValid,
   input  armIsaPkg::regIdx   resRd,
   input  armCorePkg::word    resData,
   opBus.src                  ops
);
   import armIsaPkg::*;
   import armCorePkg::*;

   logic   validQ;
   dpInstr instrQ;
   logic   known;       // Opcode is one of the kept twelve
   logic   isCompare;
   aluOp   aluSel;
   logic   arithSel;
   word    rnData;
   word    rmData;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) validQ <= 1'b0;
      else if (!hold) validQ <= instrValid;
   end

   always_ff @(posedge clk) begin
      if (!hold) instrQ <= instr;
   end

   always_comb begin
      known     = 1'b1;
      isCompare = 1'b0;
      arithSel  = 1'b0;
      aluSel    = aluAdd;
      case (instrQ.immView.opcode)
         opAdd: arithSel = 1'b1;
         opSub: begin
            aluSel   = aluSub;
            arithSel = 1'b1;
         end
         opCmn: begin
            isCompare = 1'b1;
            arithSel  = 1'b1;
         end
         opCmp: begin
            aluSel    = aluSub;
            isCompare = 1'b1;
            arithSel  = 1'b1;
         end
         opAnd: aluSel = aluAnd;
         opTst: begin
            aluSel    = aluAnd;
            isCompare = 1'b1;
         end
         opEor: aluSel = aluEor;
         opTeq: begin
            aluSel    = aluEor;
            isCompare = 1'b1;
         end
         opOrr: aluSel = aluOrr;
         opBic: aluSel = aluBic;
         opMov: aluSel = aluMov;
         opMvn: aluSel = aluMvn;
         default: known = 1'b0; // ADC, SBC, RSB, RSC
      endcase
   end

   regFile regs (
      .clk   (clk),
      .reset (reset),
      .ra1   (instrQ.immView.rn),
      .ra2   (instrQ.regView.rm),
      .rd1   (rnData),
      .rd2   (rmData),
      .we    (resValid),
      .wa    (resRd),
      .wd    (resData),
      .hold  (hold)
   );

   assign ops.valid     = validQ && known && instrQ.immView.op == 2'b00;
   assign ops.op        = aluSel;
   assign ops.cond      = instrQ.immView.cond;
   assign ops.setFlags  = instrQ.immView.s || isCompare; // Compares always set flags
   assign ops.arith     = arithSel;
   assign ops.writesReg = !isCompare;
   assign ops.rd        = instrQ.immView.rd;
   assign ops.rn        = instrQ.immView.rn;
   assign ops.rm        = instrQ.regView.rm;
   assign ops.useImm    = instrQ.immView.immBit;
   assign ops.operandA  = rnData;
   assign ops.operandB  = instrQ.immView.immBit ? {24'b0, instrQ.immView.imm8} : rmData;

endmodule

// File: executeStage.sv
module executeStage (
   input  logic               clk,
   input  logic               reset,
   input  logic               hold,
   opBus.dst                  ops,
   input  logic               resValid,
   input  armIsaPkg::regIdx   resRd,
   input  armCorePkg::word    resData,
   output logic               exValid,
   output armIsaPkg::regIdx   exRd,
   output armCorePkg::word    exData,
   output armIsaPkg::flagsT   flags
);
   import armIsaPkg::*;
   import armCorePkg::*;

   logic    validQ;
   aluOp    opQ;
   condCode condQ;
   logic    setFlagsQ;
   logic    arithQ;
   logic    writesRegQ;
   regIdx   rnQ;
   regIdx   rmQ;
   logic    useImmQ;
   word     aQ;
   word     bQ;
   word     srcA;
   word     srcB;
   flagsT   aluFlags;
   flagsT   flagsQ;
   logic    condPass;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) validQ <= 1'b0;
      else if (!hold) validQ <= ops.valid;
   end

   always_ff @(posedge clk) begin
      if (!hold) begin
         opQ        <= ops.op;
         condQ      <= ops.cond;
         setFlagsQ  <= ops.setFlags;
         arithQ     <= ops.arith;
         writesRegQ <= ops.writesReg;
         exRd       <= ops.rd;
         rnQ        <= ops.rn;
         rmQ        <= ops.rm;
         useImmQ    <= ops.useImm;
         aQ         <= ops.operandA;
         bQ         <= ops.operandB;
      end
   end

   // Forward from the result stage, the only older instruction in flight
   assign srcA = (resValid && resRd == rnQ) ? resData : aQ;
   assign srcB = (!useImmQ && resValid && resRd == rmQ) ? resData : bQ;

   aluUnit alu (
      .a        (srcA),
      .b        (srcB),
      .op       (opQ),
      .result   (exData),
      .aluFlags (aluFlags)
   );

   always_comb begin
      case (condQ)
         condEq:  condPass = flagsQ.z;
         condNe:  condPass = !flagsQ.z;
         condCs:  condPass = flagsQ.c;
         condCc:  condPass = !flagsQ.c;
         condMi:  condPass = flagsQ.n;
         condPl:  condPass = !flagsQ.n;
         condVs:  condPass = flagsQ.v;
         condVc:  condPass = !flagsQ.v;
         condHi:  condPass = flagsQ.c && !flagsQ.z;
         condLs:  condPass = !flagsQ.c || flagsQ.z;
         condGe:  condPass = flagsQ.n == flagsQ.v;
         condLt:  condPass = flagsQ.n != flagsQ.v;
         condGt:  condPass = !flagsQ.z && (flagsQ.n == flagsQ.v);
         condLe:  condPass = flagsQ.z || (flagsQ.n != flagsQ.v);
         condAl:  condPass = 1'b1;
         default: condPass = 1'b0; // NV never executes
      endcase
   end

   // Flags move with the instruction into the result stage
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flagsQ <= '0;
      end else if (!hold && validQ && condPass && setFlagsQ) begin
         flagsQ.n <= aluFlags.n;
         flagsQ.z <= aluFlags.z;
         if (arithQ) begin  // Logic ops keep C and V
            flagsQ.c <= aluFlags.c;
            flagsQ.v <= aluFlags.v;
         end
      end
   end

   assign exValid = validQ && writesRegQ && condPass;
   assign flags   = flagsQ;

endmodule

// File: resultStage.sv
module resultStage (
   input  logic               clk,
   input  logic               reset,
   input  logic               hold,
   input  logic               exValid,
   input  armIsaPkg::regIdx   exRd,
   input  armCorePkg::word    exData,
   output logic               resValid,
   output armIsaPkg::regIdx   resRd,
   output armCorePkg::word    resData
);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) resValid <= 1'b0;
      else if (!hold) resValid <= exValid;
   end

   // Payload, qualified by resValid
   always_ff @(posedge clk) begin
      if (!hold) begin
         resRd   <= exRd;
         resData <= exData;
      end
   end

endmodule

// File: armCore.sv
module armCore (
   input  logic               clk,
   input  logic               reset,
   input  logic               instrValid,
   input  armIsaPkg::dpInstr  instr,
   input  logic               hold,
   output logic               wbValid,
   output armIsaPkg::regIdx   wbReg,
   output armCorePkg::word    wbData,
   output armIsaPkg::flagsT   flags
);

   logic             exValid;
   armIsaPkg::regIdx exRd;
   armCorePkg::word  exData;

   opBus decodedOp ();

   // Result register outputs double as write-back ports
   decodeStage decode (
      .clk        (clk),
      .reset      (reset),
      .hold       (hold),
      .instrValid (instrValid),
      .instr      (instr),
      .resValid   (wbValid),
      .resRd      (wbReg),
      .resData    (wbData),
      .ops        (decodedOp.src)
   );

   executeStage execute (
      .clk      (clk),
      .reset    (reset),
      .hold     (hold),
      .ops      (decodedOp.dst),
      .resValid (wbValid),
      .resRd    (wbReg),
      .resData  (wbData),
      .exValid  (exValid),
      .exRd     (exRd),
      .exData   (exData),
      .flags    (flags)
   );

   resultStage result (
      .clk      (clk),
      .reset    (reset),
      .hold     (hold),
      .exValid  (exValid),
      .exRd     (exRd),
      .exData   (exData),
      .resValid (wbValid),
      .resRd    (wbReg),
      .resData  (wbData)
   );

endmodule

// File: armCore_chk.sv
module armCore_chk (
   input logic               clk,
   input logic               reset,
   input logic               hold,
   input logic               wbValid,
   input armIsaPkg::regIdx   wbReg,
   input logic [31:0]        wbData,
   input armIsaPkg::flagsT   flags
);

   wbValidKnown: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(wbValid))
      else $error("wbValid is unknown");

   // Whole pipeline frozen while hold is high
   holdKeepsWriteBack: assert property (@(posedge clk) disable iff (reset)
      hold |=> $stable({wbValid, wbReg, wbData}))
      else $error("Write-back outputs changed during hold");

   flagsMoveWithoutHold: assert property (@(posedge clk) disable iff (reset)
      !$stable(flags) |-> !$past(hold))
      else $error("Flags changed at an edge with hold high");

endmodule

bind armCore armCore_chk chk (
   .clk     (clk),
   .reset   (reset),
   .hold    (hold),
   .wbValid (wbValid),
   .wbReg   (wbReg),
   .wbData  (wbData),
   .flags   (flags)
);

// File: armCore_tb.sv
module armCore_tb;
   import armIsaPkg::*;

   localparam int numRandom  = 400;
   localparam int numInstr   = numRandom + 2 + 30;
   localparam int cycleLimit = 4 * numInstr + 50;

   localparam logic [3:0] keptOps [12] = '{opAnd, opEor, opSub, opAdd, opTst, opTeq,
                                           opCmp, opCmn, opOrr, opMov, opBic, opMvn};

   logic        clk;
   logic        reset;
   logic        instrValid;
   dpInstr      instr;
   logic        hold;
   logic        wbValid;
   regIdx       wbReg;
   logic [31:0] wbData;
   flagsT       flags;

   logic [31:0] randState = 32'h4f036a2c;
   logic [31:0] modelRegs [16];
   flagsT       modelFlags;
   logic [39:0] expQ [$];   // Flags, register, data
   string       nameQ [$];  // Test that issued each queued result
   logic [39:0] expected;
   string       expName;
   logic [3:0]  lastRd;
   logic [3:0]  prevRd;
   string       testName;
   int          modelCount;
   int          wbCount;
   int          checkCount;
   int          valueErrors;
   int          otherErrors;
   int          cycles;

   armCore dut (
      .clk        (clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .hold       (hold),
      .wbValid    (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .flags      (flags)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] nextRand();
      randState = randState ^ (randState << 13);
      randState = randState ^ (randState >> 17);
      randState = randState ^ (randState << 5);
      return randState;
   endfunction

   function automatic logic [31:0] makeInstr(input logic [3:0] cond, input logic immBit,
                                             input logic [3:0] opcode, input logic s,
                                             input logic [3:0] rn, input logic [3:0] rd,
                                             input logic [11:0] op2);
      return {cond, 2'b00, immBit, opcode, s, rn, rd, op2};
   endfunction

   // ARM condition table, NV never passes
   function automatic logic condHolds(input logic [3:0] c, input flagsT f);
      case (c)
         4'h0: return f.z;
         4'h1: return !f.z;
         4'h2: return f.c;
         4'h3: return !f.c;
         4'h4: return f.n;
         4'h5: return !f.n;
         4'h6: return f.v;
         4'h7: return !f.v;
         4'h8: return f.c && !f.z;
         4'h9: return !f.c || f.z;
         4'hA: return f.n == f.v;
         4'hB: return f.n != f.v;
         4'hC: return !f.z && f.n == f.v;
         4'hD: return f.z || f.n != f.v;
         4'hE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Applies one accepted word to the model and queues its write-back
   function automatic void refExecute(input logic [31:0] w);
      logic [3:0]  opcode;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic        arith;
      logic        carry;
      logic        ovf;
      logic        known;
      logic        compare;
      opcode  = w[24:21];
      a       = modelRegs[w[19:16]];
      b       = w[25] ? {24'b0, w[7:0]} : modelRegs[w[3:0]];
      res     = '0;
      arith   = 1'b0;
      carry   = 1'b0;
      ovf     = 1'b0;
      known   = 1'b1;
      compare = opcode inside {opTst, opTeq, opCmp, opCmn};
      case (opcode)
         opAdd, opCmn: begin
            {carry, res} = {1'b0, a} + {1'b0, b};
            ovf   = (a[31] == b[31]) && (res[31] != a[31]);
            arith = 1'b1;
         end
         opSub, opCmp: begin
            res   = a - b;
            carry = a >= b;   // No borrow
            ovf   = (a[31] != b[31]) && (res[31] != a[31]);
            arith = 1'b1;
         end
         opAnd, opTst: res = a & b;
         opEor, opTeq: res = a ^ b;
         opOrr: res = a | b;
         opBic: res = a & ~b;
         opMov: res = b;
         opMvn: res = ~b;
         default: known = 1'b0;
      endcase
      if (!known || w[27:26] != 2'b00 || !condHolds(w[31:28], modelFlags)) return;
      if (w[20] || compare) begin
         modelFlags.n = res[31];
         modelFlags.z = res == 32'h0;
         if (arith) begin
            modelFlags.c = carry;
            modelFlags.v = ovf;
         end
      end
      if (!compare) begin
         modelRegs[w[15:12]] = res;
         expQ.push_back({modelFlags, w[15:12], res});
         nameQ.push_back(testName);
         modelCount++;
      end
   endfunction

   function automatic logic [31:0] randomInstr();
      logic [31:0] r;
      logic [31:0] q;
      logic [3:0]  cond;
      logic [3:0]  rn;
      logic [3:0]  rm;
      logic [31:0] w;
      r    = nextRand();
      q    = nextRand();
      cond = (r[10:8] < 3'd5) ? 4'hE : q[3:0];
      if (cond == 4'hF) cond = 4'h0;
      // Chains on the last or second-last result, either operand
      rn = r[11] ? (r[27] ? prevRd : lastRd) : r[15:12];
      rm = r[16] ? (r[27] ? lastRd : prevRd) : r[20:17];
      w  = makeInstr(cond, r[25], keptOps[r[3:0] % 4'd12], r[26], rn, r[24:21],
                     r[25] ? {4'b0, q[15:8]} : {8'b0, rm});
      if (r[7:4] == 4'd0) w[24:21] = 4'b0101;   // ADC, a no-op here
      if (r[31:28] == 4'd0) w[27:26] = 2'b01;
      return w;
   endfunction

   task automatic checkValue(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
      checkCount++;
      if (act !== exp) begin
         valueErrors++;
         $display("Error: %s %s expected %h actual %h", name, field, exp, act);
      end
   endtask

   task automatic issue(input logic [31:0] w, input logic holdOn);
      logic taken;
      instr      = w;
      instrValid = 1'b1;
      taken      = 1'b0;
      while (!taken) begin
         hold  = holdOn && (nextRand() % 6 == 0);
         taken = !hold;
         @(negedge clk);
      end
      instrValid = 1'b0;
      refExecute(w);
      prevRd = lastRd;
      lastRd = w[15:12];
   endtask

   task automatic idleCycle();
      instrValid = 1'b0;
      hold       = nextRand() % 4 == 0;
      @(negedge clk);
   endtask

   // Compare each counted write-back against the oldest queued result
   always @(posedge clk) begin
      if (!reset && wbValid && !hold) begin
         wbCount++;
         if (expQ.size() == 0) begin
            otherErrors++;
            $display("Write-back to r%0d arrived with no result expected", wbReg);
         end else begin
            expected = expQ.pop_front();
            expName  = nameQ.pop_front();
            checkValue(expName, "wbReg", {28'b0, expected[35:32]}, {28'b0, wbReg});
            checkValue(expName, "wbData", expected[31:0], wbData);
            checkValue(expName, "flags", {28'b0, expected[39:36]}, {28'b0, flags});
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycleLimit) begin
         $display("Timeout after %0d cycles with %0d results outstanding",
                  cycles, expQ.size());
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      logic [31:0] r;
      reset      = 1'b1;
      instrValid = 1'b0;
      instr      = '0;
      hold       = 1'b0;
      modelFlags = '0;
      lastRd     = 4'd0;
      prevRd     = 4'd0;
      foreach (modelRegs[i]) modelRegs[i] = 32'h0;
      testName = "reset";
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      checkValue(testName, "wbValid", 32'h0, {31'b0, wbValid});
      checkValue(testName, "flags", 32'h0, {28'b0, flags});
      issue(makeInstr(4'hE, 1'b0, opAdd, 1'b0, 4'd6, 4'd5, 12'h007), 1'b0);
      issue(makeInstr(4'hE, 1'b0, opOrr, 1'b1, 4'd15, 4'd9, 12'h00e), 1'b0);

      testName = "random";
      for (int i = 0; i < numRandom; i++) begin
         if (nextRand() % 8 == 0) idleCycle();
         issue(randomInstr(), 1'b1);
      end

      // Every condition right after a compare
      testName = "conditions";
      for (int c = 0; c < 15; c++) begin
         r = nextRand();
         issue(makeInstr(4'hE, r[0], opCmp, 1'b1, r[4:1], 4'd0,
                         r[0] ? {4'b0, r[15:8]} : {8'b0, r[19:16]}), 1'b0);
         issue(makeInstr(4'(c), 1'b1, opAdd, c % 2 == 1, r[23:20], r[27:24],
                         {4'b0, r[31:24]}), 1'b0);
      end

      testName = "drain";
      hold = 1'b0;
      while (expQ.size() != 0) @(negedge clk);
      repeat (4) @(negedge clk);
      checkValue(testName, "final flags", {28'b0, modelFlags}, {28'b0, flags});
      checkValue(testName, "write-back count", modelCount, wbCount);
      $display("Summary: %0d checks, %0d value errors, %0d other errors",
               checkCount, valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: src.f
armIsaPkg.sv
armCorePkg.sv
opBus.sv
regFile.sv
aluUnit.sv
decodeStage.sv
executeStage.sv
resultStage.sv
armCore.sv
armCore_chk.sv
armCore_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module armCore_tb -f src.f
	./obj_dir/VarmCore_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Done: errors found" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
